//--- dv/axi4l_ram_properties.sv
/* AXI channel stability checks */

`timescale 1ns/1ps
`default_nettype none

module axi4l_ram_properties #(
    parameter int AXI_DATA_W = 32,
    parameter int AXI_ID_W   = 8
) (
    input wire logic                  aclk,
    input wire logic                  aresetn,
    input wire logic                  srst,
    input wire logic                  rvalid,
    input wire logic                  rready,
    input wire logic [AXI_DATA_W-1:0] rdata,
    input wire logic [AXI_ID_W-1:0]   rid,
    input wire logic                  bvalid,
    input wire logic                  bready,
    input wire logic [AXI_ID_W-1:0]   bid
);

    // Number of failed assertions
    int fails = 0;

    //////////////////////////////
    // Read channel
    //////////////////////////////

    rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        rvalid && !rready |=> rvalid)
        else begin
            fails++;
            $error("rvalid dropped before the R transfer");
        end

    rdata_stable: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        rvalid && !rready |=> $stable(rdata) && $stable(rid))
        else begin
            fails++;
            $error("rdata or rid changed while stalled");
        end

    //////////////////////////////
    // Write response channel
    //////////////////////////////

    bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn || srst)
        bvalid && !bready |=> bvalid && $stable(bid))
        else begin
            fails++;
            $error("bvalid or bid changed while stalled");
        end

    // Both resets clear pending responses
    reset_idle: assert property (@(posedge aclk)
        !aresetn || $past(srst) |-> !rvalid && !bvalid)
        else begin
            fails++;
            $error("response valid high after reset");
        end

endmodule

bind axi4l_ram axi4l_ram_properties #(
    .AXI_DATA_W (AXI_DATA_W),
    .AXI_ID_W   (AXI_ID_W)
) props0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .srst    (srst),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rid     (rid),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid)
);

`default_nettype wire

//--- dv/axi4l_ram_tb.sv
/* AXI4-lite RAM testbench */

`timescale 1ns/1ps
`default_nettype none

module axi4l_ram_tb;

    localparam int ADDR_W  = 8;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 8;
    localparam int OSTD    = 4;
    localparam int N_TESTS = 13;
    localparam int LIMIT   = 64 * N_TESTS + 200;

    // Table operations
    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_QRD  = 2;
    localparam int OP_BPWR = 3;
    localparam int OP_SRST = 4;
    localparam int OP_FILL = 5;

    logic              aclk;
    logic              aresetn;
    logic              srst;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic [ID_W-1:0]   awid;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        wstrb;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic [ID_W-1:0]   bid;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [ID_W-1:0]   arid;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic [ID_W-1:0]   rid;
    logic [1:0]        rresp;

    int                tb_op   [0:N_TESTS-1];
    logic [ADDR_W-1:0] tb_addr [0:N_TESTS-1];
    logic [ID_W-1:0]   tb_id   [0:N_TESTS-1];
    logic [DATA_W-1:0] tb_data [0:N_TESTS-1];
    logic [3:0]        tb_strb [0:N_TESTS-1];
    logic [DATA_W-1:0] tb_exp  [0:N_TESTS-1];

    // Reference memory with one entry per word
    logic [DATA_W-1:0] ref_mem [0:63];

    int errors;
    int checks;
    int cycles;
    int seed;

    axi4l_ram #(
        .AXI_ADDR_W       (ADDR_W),
        .AXI_DATA_W       (DATA_W),
        .AXI_ID_W         (ID_W),
        .OSTDREQ_NUM      (OSTD),
        .VARIABLE_LATENCY (1)
    ) dut0 (
        .aclk (aclk), .aresetn (aresetn), .srst (srst),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awid (awid),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp), .bid (bid),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rid (rid), .rresp (rresp)
    );

    always #2 aclk = ~aclk;

    // Watchdog
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [DATA_W-1:0] merge_strb(logic [DATA_W-1:0] old_w,
                                                     logic [DATA_W-1:0] new_w,
                                                     logic [3:0] strb);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_val(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic set_entry(int i, int op, logic [7:0] a, logic [7:0] id,
                             logic [31:0] d, logic [3:0] s, logic [31:0] e);
        tb_op[i]   = op;
        tb_addr[i] = a;
        tb_id[i]   = id;
        tb_data[i] = d;
        tb_strb[i] = s;
        tb_exp[i]  = e;
    endtask

    // Random ready gap of 0 to 3 cycles
    task automatic ready_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) @(posedge aclk);
    endtask

    task automatic issue_write(logic [7:0] a, logic [7:0] id, logic [31:0] d, logic [3:0] s);
        bit aw_done;
        bit w_done;
        bit aw_hs;
        bit w_hs;
        aw_done = 0;
        w_done  = 0;
        @(posedge aclk);
        awvalid <= 1'b1;
        awaddr  <= a;
        awid    <= id;
        wvalid  <= 1'b1;
        wdata   <= d;
        wstrb   <= s;
        while (!(aw_done && w_done)) begin
            @(negedge aclk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge aclk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1;
            end
        end
    endtask

    task automatic take_b(logic [7:0] exp_id);
        bit hs;
        hs = 0;
        ready_gap();
        @(posedge aclk);
        bready <= 1'b1;
        while (!hs) begin
            @(negedge aclk);
            hs = bvalid;
            if (hs) begin
                check_val("bid", bid, exp_id);
                check_val("bresp", bresp, 0);
            end
            @(posedge aclk);
        end
        bready <= 1'b0;
    endtask

    task automatic issue_read(logic [7:0] a, logic [7:0] id);
        bit hs;
        hs = 0;
        @(posedge aclk);
        arvalid <= 1'b1;
        araddr  <= a;
        arid    <= id;
        while (!hs) begin
            @(negedge aclk);
            hs = arready;
            @(posedge aclk);
        end
        arvalid <= 1'b0;
    endtask

    task automatic take_r(logic [7:0] exp_id, logic [31:0] exp_data);
        bit hs;
        hs = 0;
        ready_gap();
        @(posedge aclk);
        rready <= 1'b1;
        while (!hs) begin
            @(negedge aclk);
            hs = rvalid;
            if (hs) begin
                check_val("rid", rid, exp_id);
                check_val("rdata", rdata, exp_data);
                check_val("rresp", rresp, 0);
            end
            @(posedge aclk);
        end
        rready <= 1'b0;
    endtask

    task automatic wait_bvalid();
        do
            @(negedge aclk);
        while (!bvalid);
    endtask

    //////////////////////////////
    // Composite operations
    //////////////////////////////

    task automatic write_word(logic [7:0] a, logic [7:0] id, logic [31:0] d, logic [3:0] s);
        issue_write(a, id, d, s);
        take_b(id);
        ref_mem[a[7:2]] = merge_strb(ref_mem[a[7:2]], d, s);
    endtask

    // Reads issued with rready low until the queue fills
    task automatic queued_reads(logic [7:0] a, logic [7:0] id);
        for (int k = 0; k < OSTD; k++)
            issue_read(a + 8'(4*k), id + 8'(k));
        @(negedge aclk);
        checks++;
        if (arready) begin
            errors++;
            $display("arready stayed high with the read queue full");
        end
        fork
            for (int k = OSTD; k < OSTD + 2; k++)
                issue_read(a + 8'(4*k), id + 8'(k));
            begin
                repeat (4) @(posedge aclk);
                for (int k = 0; k < OSTD + 2; k++)
                    take_r(id + 8'(k), ref_mem[(a >> 2) + k]);
            end
        join
    endtask

    // Second write must stay queued until the first B is accepted
    task automatic blocked_writes(logic [7:0] a, logic [7:0] id, logic [31:0] d);
        logic [7:0] a1;
        a1 = a + 8'd4;
        issue_write(a, id, d, 4'hf);
        wait_bvalid();
        ref_mem[a[7:2]] = d;
        issue_write(a1, id + 8'd1, ~d, 4'hf);
        repeat (4) @(posedge aclk);
        issue_read(a1, id + 8'd2);
        take_r(id + 8'd2, ref_mem[a1[7:2]]);
        take_b(id);
        take_b(id + 8'd1);
        ref_mem[a1[7:2]] = ~d;
        issue_read(a, id + 8'd3);
        take_r(id + 8'd3, ref_mem[a[7:2]]);
        issue_read(a1, id + 8'd4);
        take_r(id + 8'd4, ref_mem[a1[7:2]]);
    endtask

    task automatic sync_reset(logic [7:0] a, logic [7:0] id, logic [31:0] d);
        issue_write(a, id, d, 4'hf);
        wait_bvalid();
        ref_mem[a[7:2]] = d;
        // Writes queued behind the pending B are dropped by srst
        for (int k = 1; k <= OSTD; k++)
            issue_write(a + 8'(4*k), id + 8'(k), ~d, 4'hf);
        for (int k = 0; k < OSTD; k++)
            issue_read(a, id + 8'(OSTD + 1 + k));
        do
            @(negedge aclk);
        while (!rvalid);
        @(posedge aclk);
        srst <= 1'b1;
        @(posedge aclk);
        srst <= 1'b0;
        @(negedge aclk);
        check_val("rvalid", rvalid, 0);
        check_val("bvalid", bvalid, 0);
        check_val("arready", arready, 1);
        check_val("awready", awready, 1);
        check_val("wready", wready, 1);
        @(posedge aclk);
        rready <= 1'b1;
        bready <= 1'b1;
        repeat (20) begin
            @(negedge aclk);
            checks++;
            if (rvalid || bvalid) begin
                errors++;
                $display("Stale response seen after synchronous reset");
            end
        end
        @(posedge aclk);
        rready <= 1'b0;
        bready <= 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int err_before;
        aclk    = 1'b0;
        aresetn = 1'b0;
        srst    = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        rready  = 1'b0;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        seed    = 32'h2a37_1167;

        set_entry(0,  OP_WR,   8'h10, 8'h01, 32'h1122_3344, 4'hf, 32'h0);
        set_entry(1,  OP_RD,   8'h10, 8'h02, 32'h0,         4'h0, 32'h1122_3344);
        set_entry(2,  OP_WR,   8'h10, 8'h03, 32'haabb_ccdd, 4'h5, 32'h0);
        set_entry(3,  OP_RD,   8'h10, 8'h04, 32'h0,         4'h0, 32'h11bb_33dd);
        set_entry(4,  OP_WR,   8'h14, 8'h05, 32'hcafe_f00d, 4'hf, 32'h0);
        set_entry(5,  OP_WR,   8'h14, 8'h06, 32'h0bad_beef, 4'h8, 32'h0);
        set_entry(6,  OP_RD,   8'h14, 8'h07, 32'h0,         4'h0, 32'h0bfe_f00d);
        set_entry(7,  OP_FILL, 8'h40, 8'h10, 32'h0,         4'hf, 32'h0);
        set_entry(8,  OP_QRD,  8'h40, 8'h20, 32'h0,         4'h0, 32'h0);
        set_entry(9,  OP_FILL, 8'h80, 8'h28, 32'h0,         4'hf, 32'h0);
        set_entry(10, OP_BPWR, 8'h80, 8'h30, 32'h89ab_cdef, 4'hf, 32'h0);
        set_entry(11, OP_SRST, 8'hc0, 8'h40, 32'h5566_7788, 4'hf, 32'h0);
        set_entry(12, OP_RD,   8'h10, 8'h50, 32'h0,         4'h0, 32'h11bb_33dd);

        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        for (int i = 0; i < N_TESTS; i++) begin
            err_before = errors;
            case (tb_op[i])
                OP_WR:   write_word(tb_addr[i], tb_id[i], tb_data[i], tb_strb[i]);
                OP_RD: begin
                    issue_read(tb_addr[i], tb_id[i]);
                    take_r(tb_id[i], tb_exp[i]);
                end
                OP_QRD:  queued_reads(tb_addr[i], tb_id[i]);
                OP_BPWR: blocked_writes(tb_addr[i], tb_id[i], tb_data[i]);
                OP_SRST: sync_reset(tb_addr[i], tb_id[i], tb_data[i]);
                OP_FILL: begin
                    // Pattern built from the full byte address
                    for (int k = 0; k < OSTD + 2; k++)
                        write_word(tb_addr[i] + 8'(4*k), tb_id[i] + 8'(k),
                                   {4{tb_addr[i] + 8'(4*k)}} ^ 32'hc35a_0000, 4'hf);
                end
                default: ;
            endcase
            $display("test %0d op %0d addr %h: %s", i, tb_op[i], tb_addr[i],
                     (errors == err_before) ? "ok" : "FAILED");
        end

        // Bound assertion failures count as errors too
        errors = errors + dut0.props0.fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/axi4l_ram.sv
/* AXI4-lite slave RAM */

`timescale 1ns/1ps
`default_nettype none

module axi4l_ram #(
    // Byte address width, storage is 2**AXI_ADDR_W bytes
    parameter int AXI_ADDR_W       = 8,
    parameter int AXI_DATA_W       = 32,
    parameter int AXI_ID_W         = 8,
    // Queue depth per channel, power of two
    parameter int OSTDREQ_NUM      = 4,
    // Pseudo-random 0 to 3 cycle read delay when set
    parameter int VARIABLE_LATENCY = 0
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                srst,
    // Write address
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [AXI_ADDR_W-1:0]               awaddr,
    input  logic [AXI_ID_W-1:0]                 awid,
    // Write data
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [AXI_DATA_W-1:0]               wdata,
    input  logic [AXI_DATA_W/8-1:0]             wstrb,
    // Write response
    output logic                                bvalid,
    input  logic                                bready,
    output logic [axi_ram_pkg::AXI_RESP_W-1:0]  bresp,
    output logic [AXI_ID_W-1:0]                 bid,
    // Read address
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [AXI_ADDR_W-1:0]               araddr,
    input  logic [AXI_ID_W-1:0]                 arid,
    // Read data
    output logic                                rvalid,
    input  logic                                rready,
    output logic [AXI_DATA_W-1:0]               rdata,
    output logic [AXI_ID_W-1:0]                 rid,
    output logic [axi_ram_pkg::AXI_RESP_W-1:0]  rresp
);

    localparam int ADDR_LSB = $clog2(AXI_DATA_W/8);
    localparam int WORD_W   = AXI_ADDR_W - ADDR_LSB;

    //////////////////////////////
    // Shared storage
    //////////////////////////////

    ram_port_if #(
        .ADDR_W (WORD_W),
        .DATA_W (AXI_DATA_W)
    ) ram_if ();

    ram_array #(
        .AXI_ADDR_W (AXI_ADDR_W),
        .AXI_DATA_W (AXI_DATA_W)
    ) ram0 (
        .aclk (aclk),
        .mem  (ram_if)
    );

    //////////////////////////////
    // Channels
    //////////////////////////////

    read_channel #(
        .AXI_ADDR_W       (AXI_ADDR_W),
        .AXI_DATA_W       (AXI_DATA_W),
        .AXI_ID_W         (AXI_ID_W),
        .OSTDREQ_NUM      (OSTDREQ_NUM),
        .VARIABLE_LATENCY (VARIABLE_LATENCY)
    ) rd_ch0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arid    (arid),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rid     (rid),
        .rresp   (rresp),
        .rready  (rready),
        .mem     (ram_if)
    );

    write_channel #(
        .AXI_ADDR_W  (AXI_ADDR_W),
        .AXI_DATA_W  (AXI_DATA_W),
        .AXI_ID_W    (AXI_ID_W),
        .OSTDREQ_NUM (OSTDREQ_NUM)
    ) wr_ch0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awid    (awid),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bid     (bid),
        .bready  (bready),
        .mem     (ram_if)
    );

endmodule

`default_nettype wire

//--- logic/axi_ram_pkg.sv
/* AXI4-lite RAM shared types */

`default_nettype none

package axi_ram_pkg;

    //////////////////////////////
    // Field widths
    //////////////////////////////

    // Width of BRESP and RRESP
    localparam int AXI_RESP_W = 2;

    // Latency LFSR width
    localparam int LFSR_W = 8;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // AXI response codes, only OKAY is ever returned
    typedef enum logic [AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // Read channel FSM
    typedef enum logic [1:0] {
        R_IDLE  = 2'd0,
        R_FETCH = 2'd1,
        R_WAIT  = 2'd2,
        R_VALID = 2'd3
    } rd_state_t;

    // Write channel FSM
    typedef enum logic {
        W_IDLE = 1'b0,
        W_RESP = 1'b1
    } wr_state_t;

endpackage

`default_nettype wire

//--- logic/ram_array.sv
/* Byte-strobed word storage */

`timescale 1ns/1ps
`default_nettype none

module ram_array #(
    parameter int AXI_ADDR_W = 8,
    parameter int AXI_DATA_W = 32
) (
    input  logic         aclk,
    ram_port_if.mem      mem
);

    localparam int ADDR_LSB = $clog2(AXI_DATA_W/8);
    localparam int WORD_W   = AXI_ADDR_W - ADDR_LSB;
    localparam int NB_BYTES = AXI_DATA_W/8;

    logic [AXI_DATA_W-1:0] words [0:2**WORD_W-1];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (mem.wr_en) begin
            // Only the strobed lanes are updated
            for (int i = 0; i < NB_BYTES; i++) begin
                if (mem.wr_strb[i])
                    words[mem.wr_addr][8*i +: 8] <= mem.wr_data[8*i +: 8];
            end
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Data stays on rd_data until the next read
    always_ff @(posedge aclk) begin
        if (mem.rd_en)
            mem.rd_data <= words[mem.rd_addr];
    end

endmodule

`default_nettype wire

//--- logic/ram_port_if.sv
/* Memory port bundle */

`timescale 1ns/1ps
`default_nettype none

interface ram_port_if #(
    // Word index width
    parameter int ADDR_W = 6,
    parameter int DATA_W = 32
);

    // Read port
    logic                  rd_en;
    logic [ADDR_W-1:0]     rd_addr;
    logic [DATA_W-1:0]     rd_data;

    // Write port, one strobe bit per byte lane
    logic                  wr_en;
    logic [ADDR_W-1:0]     wr_addr;
    logic [DATA_W-1:0]     wr_data;
    logic [DATA_W/8-1:0]   wr_strb;

    // Storage side
    modport mem (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data, wr_strb,
        output rd_data
    );

    // Read channel side
    modport rd_master (
        output rd_en, rd_addr,
        input  rd_data
    );

    // Write channel side
    modport wr_master (
        output wr_en, wr_addr, wr_data, wr_strb
    );

endinterface

`default_nettype wire

//--- logic/read_channel.sv
/* AXI4-lite read channel */

`timescale 1ns/1ps
`default_nettype none

module read_channel #(
    parameter int AXI_ADDR_W       = 8,
    parameter int AXI_DATA_W       = 32,
    parameter int AXI_ID_W         = 8,
    parameter int OSTDREQ_NUM      = 4,
    parameter int VARIABLE_LATENCY = 0
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                srst,
    input  logic                                arvalid,
    input  logic [AXI_ADDR_W-1:0]               araddr,
    input  logic [AXI_ID_W-1:0]                 arid,
    output logic                                arready,
    output logic                                rvalid,
    output logic [AXI_DATA_W-1:0]               rdata,
    output logic [AXI_ID_W-1:0]                 rid,
    output logic [axi_ram_pkg::AXI_RESP_W-1:0]  rresp,
    input  logic                                rready,
    ram_port_if.rd_master                       mem
);

    import axi_ram_pkg::*;

    localparam int ADDR_LSB = $clog2(AXI_DATA_W/8);
    localparam int WORD_W   = AXI_ADDR_W - ADDR_LSB;

    rd_state_t             state;
    logic [1:0]            wait_cnt;
    logic [1:0]            delay;
    logic [LFSR_W-1:0]     lfsr;
    logic                  q_full;
    logic                  q_empty;
    logic                  q_pull;
    logic [AXI_ID_W-1:0]   head_id;
    logic [WORD_W-1:0]     head_addr;

    //////////////////////////////
    // Address queue
    //////////////////////////////

    req_fifo #(
        .DEPTH (OSTDREQ_NUM),
        .WIDTH (AXI_ID_W + WORD_W)
    ) ar_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (arvalid),
        .data_in  ({arid, araddr[AXI_ADDR_W-1:ADDR_LSB]}),
        .full     (q_full),
        .pull     (q_pull),
        .data_out ({head_id, head_addr}),
        .empty    (q_empty)
    );

    assign arready = ~q_full;
    assign q_pull  = rvalid & rready;

    //////////////////////////////
    // Latency source
    //////////////////////////////

    // x^8 + x^6 + x^5 + x^4 + 1, stepped once per response
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            lfsr <= 8'hb5;
        else if (srst)
            lfsr <= 8'hb5;
        else if (q_pull)
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end

    assign delay = (VARIABLE_LATENCY != 0) ? lfsr[1:0] : 2'd0;

    //////////////////////////////
    // Response FSM
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= R_IDLE;
            wait_cnt <= 2'd0;
        end else if (srst) begin
            state    <= R_IDLE;
            wait_cnt <= 2'd0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (!q_empty)
                        state <= R_FETCH;
                end
                R_FETCH: begin
                    // Memory read issued this cycle
                    if (delay == 2'd0) begin
                        state <= R_VALID;
                    end else begin
                        wait_cnt <= delay - 2'd1;
                        state    <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (wait_cnt == 2'd0)
                        state <= R_VALID;
                    else
                        wait_cnt <= wait_cnt - 2'd1;
                end
                R_VALID: begin
                    if (rready)
                        state <= R_IDLE;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    assign mem.rd_en   = (state == R_FETCH);
    assign mem.rd_addr = head_addr;

    // Head entry stays in the queue until the R transfer
    assign rvalid = (state == R_VALID);
    assign rdata  = mem.rd_data;
    assign rid    = head_id;
    assign rresp  = OKAY;

endmodule

`default_nettype wire

//--- logic/req_fifo.sv
/* Outstanding request FIFO */

`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    // Number of entries, power of two
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             srst,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    input  logic             pull,
    output logic [WIDTH-1:0] data_out,
    output logic             empty
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] slots [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic             push_ok;
    logic             pull_ok;

    // Requests past the edges of the buffer are dropped
    assign push_ok    = push & ~full;
    assign pull_ok    = pull & ~empty;
    assign wr_ptr_nxt = wr_ptr + 1'b1;
    assign rd_ptr_nxt = rd_ptr + 1'b1;

    //////////////////////////////
    // Pointers and flags
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr_nxt;
            if (pull_ok)
                rd_ptr <= rd_ptr_nxt;
            // Simultaneous push and pull leave the fill level unchanged
            case ({push_ok, pull_ok})
                2'b10: begin
                    empty <= 1'b0;
                    full  <= (wr_ptr_nxt == rd_ptr);
                end
                2'b01: begin
                    full  <= 1'b0;
                    empty <= (rd_ptr_nxt == wr_ptr);
                end
                default: ;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge aclk) begin
        if (push_ok)
            slots[wr_ptr] <= data_in;
    end

    assign data_out = slots[rd_ptr];

endmodule

`default_nettype wire

//--- logic/write_channel.sv
/* AXI4-lite write channel */

`timescale 1ns/1ps
`default_nettype none

module write_channel #(
    parameter int AXI_ADDR_W  = 8,
    parameter int AXI_DATA_W  = 32,
    parameter int AXI_ID_W    = 8,
    parameter int OSTDREQ_NUM = 4
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                srst,
    input  logic                                awvalid,
    input  logic [AXI_ADDR_W-1:0]               awaddr,
    input  logic [AXI_ID_W-1:0]                 awid,
    output logic                                awready,
    input  logic                                wvalid,
    input  logic [AXI_DATA_W-1:0]               wdata,
    input  logic [AXI_DATA_W/8-1:0]             wstrb,
    output logic                                wready,
    output logic                                bvalid,
    output logic [axi_ram_pkg::AXI_RESP_W-1:0]  bresp,
    output logic [AXI_ID_W-1:0]                 bid,
    input  logic                                bready,
    ram_port_if.wr_master                       mem
);

    import axi_ram_pkg::*;

    localparam int ADDR_LSB = $clog2(AXI_DATA_W/8);
    localparam int WORD_W   = AXI_ADDR_W - ADDR_LSB;
    localparam int STRB_W   = AXI_DATA_W/8;

    wr_state_t               state;
    logic                    commit;
    logic [AXI_ID_W-1:0]     bid_q;

    logic                    aw_full;
    logic                    aw_empty;
    logic [AXI_ID_W-1:0]     aw_id_head;
    logic [WORD_W-1:0]       aw_addr_head;

    logic                    w_full;
    logic                    w_empty;
    logic [STRB_W-1:0]       w_strb_head;
    logic [AXI_DATA_W-1:0]   w_data_head;

    //////////////////////////////
    // Request queues
    //////////////////////////////

    req_fifo #(
        .DEPTH (OSTDREQ_NUM),
        .WIDTH (AXI_ID_W + WORD_W)
    ) aw_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (awvalid),
        .data_in  ({awid, awaddr[AXI_ADDR_W-1:ADDR_LSB]}),
        .full     (aw_full),
        .pull     (commit),
        .data_out ({aw_id_head, aw_addr_head}),
        .empty    (aw_empty)
    );

    req_fifo #(
        .DEPTH (OSTDREQ_NUM),
        .WIDTH (STRB_W + AXI_DATA_W)
    ) w_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (wvalid),
        .data_in  ({wstrb, wdata}),
        .full     (w_full),
        .pull     (commit),
        .data_out ({w_strb_head, w_data_head}),
        .empty    (w_empty)
    );

    assign awready = ~aw_full;
    assign wready  = ~w_full;

    //////////////////////////////
    // Commit and response
    //////////////////////////////

    // Address and data are paired in arrival order
    assign commit = (state == W_IDLE) & ~aw_empty & ~w_empty;

    assign mem.wr_en   = commit;
    assign mem.wr_addr = aw_addr_head;
    assign mem.wr_data = w_data_head;
    assign mem.wr_strb = w_strb_head;

    // One write in flight, held in W_RESP until bready
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= W_IDLE;
        end else if (srst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (commit)
                        state <= W_RESP;
                end
                W_RESP: begin
                    if (bready)
                        state <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // ID of the committed write
    always_ff @(posedge aclk) begin
        if (commit)
            bid_q <= aw_id_head;
    end

    assign bvalid = (state == W_RESP);
    assign bid    = bid_q;
    assign bresp  = OKAY;

endmodule

`default_nettype wire

//--- project.f
logic/axi_ram_pkg.sv
logic/ram_port_if.sv
logic/req_fifo.sv
logic/ram_array.sv
logic/read_channel.sv
logic/write_channel.sv
logic/axi4l_ram.sv
dv/axi4l_ram_properties.sv
dv/axi4l_ram_tb.sv
